//--- common/fw_mem_pkg.sv
// Shared bus and RAM types for the firmware memory subsystem, referenced by scoped names

package fw_mem_pkg;

  // --------------------
  // Field widths
  // --------------------

  // Word address on the CPU-side bus
  localparam int ADDR_W = 12;
  // Region code in the top address bits
  localparam int REGION_W = 2;
  // Word offset inside one region
  localparam int INDEX_W = ADDR_W - REGION_W;
  localparam int DATA_W = 32;
  // One write enable per byte lane
  localparam int BE_W = DATA_W / 8;

  // --------------------
  // Region codes, addr[11:10]
  // --------------------

  localparam logic [REGION_W-1:0] REGION_FW   = 2'd0;
  localparam logic [REGION_W-1:0] REGION_APP  = 2'd1;
  localparam logic [REGION_W-1:0] REGION_CTRL = 2'd2;
  // Never mapped, also used for out-of-range offsets
  localparam logic [REGION_W-1:0] REGION_NONE = 2'd3;

  // --------------------
  // Bus side
  // --------------------

  // Request, all-zero we means read
  typedef struct packed {
    logic              cs;
    logic [BE_W-1:0]   we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // Response, one cycle after cs
  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // --------------------
  // RAM side
  // --------------------

  // Request to one RAM, index already stripped of the region code
  typedef struct packed {
    logic               cs;
    logic [BE_W-1:0]    we;
    logic [INDEX_W-1:0] index;
    logic [DATA_W-1:0]  wdata;
  } ram_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } ram_rsp_t;

endpackage

//--- flist.f
common/fw_mem_pkg.sv
fw_ram/fw_ram.sv
rtl/app_ram.sv
rtl/mem_bus_ctrl.sv
rtl/fw_mem_top.sv
verif/tb_clkgen.sv
verif/fw_mem_chk.sv
verif/fw_mem_tb.sv

//--- fw_ram/fw_ram.sv
// Firmware RAM with byte writes, locked by the application-mode bit; used under fw_mem_top

`timescale 1ns/1ps

module fw_ram #(
  parameter int unsigned DEPTH = 256
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 fw_app_mode,
  input  fw_mem_pkg::ram_req_t req,
  output fw_mem_pkg::ram_rsp_t rsp
);

  // Index bits actually decoded
  localparam int IDX_W = $clog2(DEPTH);

  // --------------------
  // Storage and strobes
  // --------------------

  // Behavioral array, no reset
  logic [fw_mem_pkg::DATA_W-1:0] mem [DEPTH];
  logic [fw_mem_pkg::DATA_W-1:0] rd_data_reg;
  logic [IDX_W-1:0]              idx;

  // Access allowed only outside application mode
  logic fw_cs;
  logic wr_en;
  logic rd_en;

  logic ready_reg;
  // Last access was a permitted read
  logic rd_ok_reg;

  assign idx   = req.index[IDX_W-1:0];
  assign fw_cs = req.cs && !fw_app_mode;
  // Any byte lane enabled makes it a write
  assign wr_en = fw_cs && (|req.we);
  assign rd_en = fw_cs && !(|req.we);

  // --------------------
  // Array access
  // --------------------

  always_ff @(posedge clk) begin
    // Per-lane merge, untouched lanes keep old bytes
    for (int b = 0; b < fw_mem_pkg::BE_W; b++) begin
      if (wr_en && req.we[b]) begin
        mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
    // Read data registered
    if (rd_en) begin
      rd_data_reg <= mem[idx];
    end
  end

  // Ready follows cs even when locked
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
      rd_ok_reg <= 1'b0;
    end else begin
      ready_reg <= req.cs;
      rd_ok_reg <= rd_en;
    end
  end

  // Locked reads and all writes return zero
  assign rsp.ready = ready_reg;
  assign rsp.rdata = rd_ok_reg ? rd_data_reg : '0;

endmodule

//--- rtl/app_ram.sv
// Unrestricted application RAM with byte writes and a registered read; used under fw_mem_top

`timescale 1ns/1ps

module app_ram #(
  parameter int unsigned DEPTH = 512
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  fw_mem_pkg::ram_req_t req,
  output fw_mem_pkg::ram_rsp_t rsp
);

  localparam int IDX_W = $clog2(DEPTH);

  // --------------------
  // Storage and strobes
  // --------------------

  logic [fw_mem_pkg::DATA_W-1:0] mem [DEPTH];
  logic [fw_mem_pkg::DATA_W-1:0] rd_data_reg;
  logic [IDX_W-1:0]              idx;
  logic                          wr_en;
  logic                          rd_en;
  logic                          ready_reg;
  // Response carries data only for reads
  logic                          rd_reg;

  assign idx   = req.index[IDX_W-1:0];
  assign wr_en = req.cs && (|req.we);
  assign rd_en = req.cs && !(|req.we);

  // Byte-lane writes, registered read
  always_ff @(posedge clk) begin
    for (int b = 0; b < fw_mem_pkg::BE_W; b++) begin
      if (wr_en && req.we[b]) begin
        mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
    if (rd_en) begin
      rd_data_reg <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
      rd_reg    <= 1'b0;
    end else begin
      ready_reg <= req.cs;
      rd_reg    <= rd_en;
    end
  end

  assign rsp.ready = ready_reg;
  // Writes answer with zero
  assign rsp.rdata = rd_reg ? rd_data_reg : '0;

endmodule

//--- rtl/fw_mem_top.sv
// Top level of the firmware memory subsystem; one bus port into controller and two RAMs

`timescale 1ns/1ps

module fw_mem_top #(
  parameter int unsigned FW_DEPTH  = 256,
  parameter int unsigned APP_DEPTH = 512
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  fw_mem_pkg::mem_req_t req,
  output fw_mem_pkg::mem_rsp_t rsp,
  // Lock state for the rest of the SoC
  output logic                 fw_app_mode
);

  // --------------------
  // Internal RAM links
  // --------------------

  fw_mem_pkg::ram_req_t fw_req;
  fw_mem_pkg::ram_req_t app_req;
  fw_mem_pkg::ram_rsp_t fw_rsp;
  fw_mem_pkg::ram_rsp_t app_rsp;

  // Decode, mode bit and response mux
  mem_bus_ctrl #(
    .FW_DEPTH  (FW_DEPTH),
    .APP_DEPTH (APP_DEPTH)
  ) u_bus_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .req         (req),
    .rsp         (rsp),
    .fw_req      (fw_req),
    .app_req     (app_req),
    .fw_rsp      (fw_rsp),
    .app_rsp     (app_rsp),
    .fw_app_mode (fw_app_mode)
  );

  // Locked by fw_app_mode
  fw_ram #(
    .DEPTH (FW_DEPTH)
  ) u_fw_ram (
    .clk         (clk),
    .reset_n     (reset_n),
    .fw_app_mode (fw_app_mode),
    .req         (fw_req),
    .rsp         (fw_rsp)
  );

  app_ram #(
    .DEPTH (APP_DEPTH)
  ) u_app_ram (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (app_req),
    .rsp     (app_rsp)
  );

endmodule

//--- rtl/mem_bus_ctrl.sv
// Bus decoder for the memory subsystem: region select, mode register and response mux

`timescale 1ns/1ps

module mem_bus_ctrl #(
  parameter int unsigned FW_DEPTH  = 256,
  parameter int unsigned APP_DEPTH = 512
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  fw_mem_pkg::mem_req_t req,
  output fw_mem_pkg::mem_rsp_t rsp,
  output fw_mem_pkg::ram_req_t fw_req,
  output fw_mem_pkg::ram_req_t app_req,
  input  fw_mem_pkg::ram_rsp_t fw_rsp,
  input  fw_mem_pkg::ram_rsp_t app_rsp,
  output logic                 fw_app_mode
);

  // --------------------
  // Address decode
  // --------------------

  logic [fw_mem_pkg::REGION_W-1:0] region;
  logic [fw_mem_pkg::INDEX_W-1:0]  offset;

  assign region = req.addr[fw_mem_pkg::ADDR_W-1 -: fw_mem_pkg::REGION_W];
  assign offset = req.addr[fw_mem_pkg::INDEX_W-1:0];

  // Offsets at or past the depth are unmapped
  logic fw_hit;
  logic app_hit;
  logic ctrl_hit;
  logic is_write;

  assign fw_hit   = req.cs && (region == fw_mem_pkg::REGION_FW) &&
                    (32'(offset) < FW_DEPTH);
  assign app_hit  = req.cs && (region == fw_mem_pkg::REGION_APP) &&
                    (32'(offset) < APP_DEPTH);
  // Single word, whole region aliases it
  assign ctrl_hit = req.cs && (region == fw_mem_pkg::REGION_CTRL);
  assign is_write = |req.we;

  // Same payload to both RAMs, only cs differs
  assign fw_req.cs     = fw_hit;
  assign fw_req.we     = req.we;
  assign fw_req.index  = offset;
  assign fw_req.wdata  = req.wdata;

  assign app_req.cs    = app_hit;
  assign app_req.we    = req.we;
  assign app_req.index = offset;
  assign app_req.wdata = req.wdata;

  // --------------------
  // Application-mode bit
  // --------------------

  // Sticky, only reset clears it
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fw_app_mode <= 1'b0;
    end else if (ctrl_hit && req.we[0] && req.wdata[0]) begin
      fw_app_mode <= 1'b1;
    end
  end

  // --------------------
  // Response stage
  // --------------------

  // Region of the request in flight
  logic [fw_mem_pkg::REGION_W-1:0] rsp_sel_reg;
  // Ready for control and unmapped accesses
  logic                            local_ready_reg;
  // Control read, returns the mode bit
  logic                            ctrl_rd_reg;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rsp_sel_reg     <= fw_mem_pkg::REGION_NONE;
      local_ready_reg <= 1'b0;
      ctrl_rd_reg     <= 1'b0;
    end else begin
      if (fw_hit) begin
        rsp_sel_reg <= fw_mem_pkg::REGION_FW;
      end else if (app_hit) begin
        rsp_sel_reg <= fw_mem_pkg::REGION_APP;
      end else if (ctrl_hit) begin
        rsp_sel_reg <= fw_mem_pkg::REGION_CTRL;
      end else begin
        rsp_sel_reg <= fw_mem_pkg::REGION_NONE;
      end
      local_ready_reg <= req.cs && !fw_hit && !app_hit;
      ctrl_rd_reg     <= ctrl_hit && !is_write;
    end
  end

  // Mode cannot change between a read and its response
  always_comb begin
    case (rsp_sel_reg)
      fw_mem_pkg::REGION_FW: begin
        rsp.ready = fw_rsp.ready;
        rsp.rdata = fw_rsp.rdata;
      end
      fw_mem_pkg::REGION_APP: begin
        rsp.ready = app_rsp.ready;
        rsp.rdata = app_rsp.rdata;
      end
      fw_mem_pkg::REGION_CTRL: begin
        rsp.ready = local_ready_reg;
        rsp.rdata = {31'd0, ctrl_rd_reg && fw_app_mode};
      end
      default: begin
        // Unmapped reads as zero
        rsp.ready = local_ready_reg;
        rsp.rdata = '0;
      end
    endcase
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the fw_mem_top testbench with Verilator; exit status is the verdict
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module fw_mem_tb \
  -f flist.f \
  -o sim_fw_mem

./obj_dir/sim_fw_mem

//--- verif/fw_mem_chk.sv
// Assertion checker bound into fw_mem_top: response timing, sticky mode bit, firmware lock

`timescale 1ns/1ps

module fw_mem_chk (
  input logic                 clk,
  input logic                 reset_n,
  input fw_mem_pkg::mem_req_t req,
  input fw_mem_pkg::mem_rsp_t rsp,
  input logic                 fw_app_mode,
  // Gated write strobe inside the firmware RAM
  input logic                 fw_wr_en
);

  // --------------------
  // Response timing
  // --------------------

  // Every cs answered on the next cycle
  ready_after_cs: assert property (@(posedge clk) disable iff (!reset_n)
    req.cs |=> rsp.ready)
    else $error("ready did not follow cs after one cycle");

  // No ready without a request one cycle earlier
  ready_only_after_cs: assert property (@(posedge clk) disable iff (!reset_n)
    !req.cs |=> !rsp.ready)
    else $error("ready asserted without a request in the previous cycle");

  // --------------------
  // Lock
  // --------------------

  // Lock write seen on the bus, tracked apart from the mode register
  logic lock_seen;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      lock_seen <= 1'b0;
    end else if (req.cs &&
                 (req.addr[fw_mem_pkg::ADDR_W-1 -: fw_mem_pkg::REGION_W] ==
                  fw_mem_pkg::REGION_CTRL) &&
                 req.we[0] && req.wdata[0]) begin
      lock_seen <= 1'b1;
    end
  end

  // Only reset clears the mode bit
  mode_is_sticky: assert property (@(posedge clk) disable iff (!reset_n)
    fw_app_mode |=> fw_app_mode)
    else $error("application mode bit fell while out of reset");

  no_locked_fw_write: assert property (@(posedge clk) disable iff (!reset_n)
    lock_seen |-> !fw_wr_en)
    else $error("firmware RAM write strobe while application mode is set");

endmodule

bind fw_mem_top fw_mem_chk u_chk (
  .clk         (clk),
  .reset_n     (reset_n),
  .req         (req),
  .rsp         (rsp),
  .fw_app_mode (fw_app_mode),
  .fw_wr_en    (u_fw_ram.wr_en)
);

//--- verif/fw_mem_tb.sv
// Self-checking testbench for fw_mem_top; compiled from flist.f and run by run_sim.sh

`timescale 1ns/1ps

module fw_mem_tb;

  localparam int FW_DEPTH    = 256;
  localparam int APP_DEPTH   = 512;
  localparam int FW_IDX_W    = $clog2(FW_DEPTH);
  localparam int APP_IDX_W   = $clog2(APP_DEPTH);
  // Words addressable inside one region code
  localparam int REGION_SPAN = 1 << fw_mem_pkg::INDEX_W;
  localparam int unsigned RAND_SEED = 69540;

  // Requests per phase
  localparam int N_FILL      = FW_DEPTH + APP_DEPTH;
  localparam int N_FULL      = 32;
  localparam int N_BYTE      = 64;
  localparam int N_UNMAP     = 24;
  localparam int N_LOCK      = 61;
  localparam int N_RAND      = 400;
  localparam int NUM_REQS    = N_FILL + N_FULL + N_BYTE + N_UNMAP + N_LOCK + N_RAND;
  localparam int CYCLE_LIMIT = 2 * NUM_REQS + 100;

  logic                 clk;
  logic                 reset_n;
  logic                 reset_req;
  fw_mem_pkg::mem_req_t req;
  fw_mem_pkg::mem_rsp_t rsp;
  logic                 fw_app_mode;

  // Expected rdata of the request on the bus
  logic [31:0] exp_rdata;
  // Reference state
  logic [31:0] fw_model [FW_DEPTH];
  logic [31:0] app_model [APP_DEPTH];
  logic        mode_model;
  int          issued = 0;
  int          checked = 0;

  tb_clkgen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (3)
  ) u_clkgen (
    .reset_req (reset_req),
    .clk       (clk),
    .reset_n   (reset_n)
  );

  fw_mem_top #(
    .FW_DEPTH  (FW_DEPTH),
    .APP_DEPTH (APP_DEPTH)
  ) u_dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .req         (req),
    .rsp         (rsp),
    .fw_app_mode (fw_app_mode)
  );

  // --------------------
  // Reference model
  // --------------------

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  // Applies one request to the model, returns the rdata the bus must show
  function automatic logic [31:0] predict_rdata(input fw_mem_pkg::mem_req_t r);
    logic [1:0]  region;
    logic [9:0]  off;
    logic        wr;
    logic [31:0] result;
    region = r.addr[11:10];
    off    = r.addr[9:0];
    wr     = (r.we != 4'h0);
    result = '0;
    case (region)
      fw_mem_pkg::REGION_FW: begin
        // Locked or out of range, nothing happens and zero returns
        if (int'(off) < FW_DEPTH && !mode_model) begin
          if (wr) begin
            fw_model[off[FW_IDX_W-1:0]] = merge_bytes(fw_model[off[FW_IDX_W-1:0]],
                                                      r.wdata, r.we);
          end else begin
            result = fw_model[off[FW_IDX_W-1:0]];
          end
        end
      end
      fw_mem_pkg::REGION_APP: begin
        if (int'(off) < APP_DEPTH) begin
          if (wr) begin
            app_model[off[APP_IDX_W-1:0]] = merge_bytes(app_model[off[APP_IDX_W-1:0]],
                                                        r.wdata, r.we);
          end else begin
            result = app_model[off[APP_IDX_W-1:0]];
          end
        end
      end
      fw_mem_pkg::REGION_CTRL: begin
        // Any offset hits the one mode word
        if (wr) begin
          if (r.we[0] && r.wdata[0]) mode_model = 1'b1;
        end else begin
          result = {31'd0, mode_model};
        end
      end
      default: result = '0;
    endcase
    return result;
  endfunction

  function automatic logic [11:0] make_addr(input logic [1:0] region, input int unsigned offset);
    return {region, offset[fw_mem_pkg::INDEX_W-1:0]};
  endfunction

  // Initial contents, distinct for every address
  function automatic logic [31:0] fill_word(input logic [11:0] addr);
    return {4'ha, addr, 4'h5, ~addr};
  endfunction

  // --------------------
  // Driver tasks
  // --------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // One request per falling edge, expectation set alongside it
  task automatic issue(input logic [3:0] we, input logic [11:0] addr, input logic [31:0] wdata);
    fw_mem_pkg::mem_req_t next_req;
    next_req.cs    = 1'b1;
    next_req.we    = we;
    next_req.addr  = addr;
    next_req.wdata = wdata;
    @(negedge clk);
    exp_rdata = predict_rdata(next_req);
    req       = next_req;
    issued++;
  endtask

  task automatic go_idle();
    @(negedge clk);
    req.cs = 1'b0;
    req.we = 4'h0;
  endtask

  task automatic pulse_reset();
    @(negedge clk);
    reset_req = 1'b1;
    @(negedge reset_n);
    // RAM contents survive, mode bit does not
    mode_model = 1'b0;
    reset_req  = 1'b0;
    @(posedge reset_n);
  endtask

  task automatic fill_memories();
    for (int i = 0; i < FW_DEPTH; i++) begin
      issue(4'hf, make_addr(fw_mem_pkg::REGION_FW, i),
            fill_word(make_addr(fw_mem_pkg::REGION_FW, i)));
    end
    for (int i = 0; i < APP_DEPTH; i++) begin
      issue(4'hf, make_addr(fw_mem_pkg::REGION_APP, i),
            fill_word(make_addr(fw_mem_pkg::REGION_APP, i)));
    end
  endtask

  // Write then read back, both RAMs
  task automatic full_word_test();
    int unsigned fw_idx;
    int unsigned app_idx;
    logic [31:0] data;
    for (int i = 0; i < 8; i++) begin
      fw_idx  = (i * 31 + 5) % FW_DEPTH;
      app_idx = (i * 61 + 7) % APP_DEPTH;
      data    = $urandom;
      issue(4'hf, make_addr(fw_mem_pkg::REGION_FW, fw_idx), data);
      issue(4'h0, make_addr(fw_mem_pkg::REGION_FW, fw_idx), '0);
      issue(4'hf, make_addr(fw_mem_pkg::REGION_APP, app_idx), ~data);
      issue(4'h0, make_addr(fw_mem_pkg::REGION_APP, app_idx), '0);
    end
  endtask

  task automatic byte_enable_test();
    logic [11:0] addr;
    logic [3:0]  be;
    for (int i = 0; i < 32; i++) begin
      if (i % 2 == 0) begin
        addr = make_addr(fw_mem_pkg::REGION_FW, $urandom % FW_DEPTH);
      end else begin
        addr = make_addr(fw_mem_pkg::REGION_APP, $urandom % APP_DEPTH);
      end
      // Never all-zero, that would be a read
      be = 4'($urandom % 15 + 1);
      issue(be, addr, $urandom);
      issue(4'h0, addr, '0);
    end
  endtask

  task automatic unmapped_test();
    logic [11:0] addr_list [8];
    int unsigned off;
    for (int i = 0; i < 8; i++) begin
      case (i % 3)
        0: addr_list[i] = make_addr(fw_mem_pkg::REGION_FW,
                                    FW_DEPTH + $urandom % (REGION_SPAN - FW_DEPTH));
        1: addr_list[i] = make_addr(fw_mem_pkg::REGION_APP,
                                    APP_DEPTH + $urandom % (REGION_SPAN - APP_DEPTH));
        default: addr_list[i] = make_addr(fw_mem_pkg::REGION_NONE, $urandom % REGION_SPAN);
      endcase
      issue(4'hf, addr_list[i], $urandom);
      issue(4'h0, addr_list[i], '0);
    end
    // RAM words an offset would fold onto if depth were ignored
    for (int i = 0; i < 8; i++) begin
      off = int'(addr_list[i][9:0]);
      if (addr_list[i][11:10] == fw_mem_pkg::REGION_FW) begin
        issue(4'h0, make_addr(fw_mem_pkg::REGION_FW, off % FW_DEPTH), '0);
      end else begin
        issue(4'h0, make_addr(fw_mem_pkg::REGION_APP, off % APP_DEPTH), '0);
      end
    end
  endtask

  // Control register, lock, then reset with firmware contents kept
  task automatic lock_test();
    for (int i = 0; i < 8; i++) begin
      issue(4'hf, make_addr(fw_mem_pkg::REGION_FW, i * 29 + 3), {16'hc0de, 16'(i)});
    end
    issue(4'h1, make_addr(fw_mem_pkg::REGION_CTRL, 0), 32'h1);
    issue(4'h0, make_addr(fw_mem_pkg::REGION_CTRL, 5), '0);
    issue(4'hf, make_addr(fw_mem_pkg::REGION_CTRL, 0), 32'h0);
    issue(4'h0, make_addr(fw_mem_pkg::REGION_CTRL, 0), '0);
    for (int i = 0; i < 8; i++) issue(4'h0, make_addr(fw_mem_pkg::REGION_FW, i * 29 + 3), '0);
    for (int i = 0; i < 8; i++) begin
      issue(4'hf, make_addr(fw_mem_pkg::REGION_FW, i * 29 + 3), $urandom);
    end
    for (int i = 0; i < 8; i++) issue(4'h0, make_addr(fw_mem_pkg::REGION_FW, i * 29 + 3), '0);
    for (int i = 0; i < 8; i++) begin
      issue(4'hf, make_addr(fw_mem_pkg::REGION_APP, i * 53 + 1), $urandom);
      issue(4'h0, make_addr(fw_mem_pkg::REGION_APP, i * 53 + 1), '0);
    end
    go_idle();
    pulse_reset();
    for (int i = 0; i < 8; i++) issue(4'h0, make_addr(fw_mem_pkg::REGION_FW, i * 29 + 3), '0);
    issue(4'h0, make_addr(fw_mem_pkg::REGION_CTRL, 0), '0);
  endtask

  // Mixed traffic, lock set halfway through
  task automatic random_traffic();
    int unsigned region;
    logic [11:0] addr;
    logic [3:0]  we;
    logic [31:0] wdata;
    for (int i = 0; i < N_RAND; i++) begin
      region = $urandom % 4;
      we     = ($urandom % 2 == 0) ? 4'h0 : 4'($urandom);
      wdata  = $urandom;
      case (region)
        0: addr = make_addr(fw_mem_pkg::REGION_FW, $urandom % (FW_DEPTH + 32));
        1: addr = make_addr(fw_mem_pkg::REGION_APP, $urandom % (APP_DEPTH + 32));
        2: begin
          addr     = make_addr(fw_mem_pkg::REGION_CTRL, $urandom % REGION_SPAN);
          // Random control writes never lock
          wdata[0] = 1'b0;
        end
        default: addr = make_addr(fw_mem_pkg::REGION_NONE, $urandom % REGION_SPAN);
      endcase
      if (i == N_RAND / 2) begin
        issue(4'h1, make_addr(fw_mem_pkg::REGION_CTRL, 0), 32'h1);
      end else begin
        issue(we, addr, wdata);
      end
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------

  initial begin : stimulus
    req        = '0;
    reset_req  = 1'b0;
    exp_rdata  = '0;
    mode_model = 1'b0;
    void'($urandom(RAND_SEED));
    wait (reset_n === 1'b1);
    fill_memories();
    full_word_test();
    byte_enable_test();
    unmapped_test();
    lock_test();
    random_traffic();
    go_idle();
    repeat (3) @(negedge clk);
    if (checked == issued) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run($sformatf("only %0d of %0d responses were checked", checked, issued));
    end
  end

  // --------------------
  // Compare
  // --------------------

  // Latch at the rising edge, check the registered response at the falling edge
  initial begin : compare
    logic        pend_cs;
    logic        pend_mode;
    logic [31:0] pend_rdata;
    forever begin
      @(posedge clk);
      pend_cs    = req.cs && reset_n;
      pend_mode  = mode_model;
      pend_rdata = exp_rdata;
      @(negedge clk);
      assert (rsp.ready === pend_cs) else begin
        abort_run($sformatf("error: rsp.ready expected 0x%0h got 0x%0h", pend_cs, rsp.ready));
      end
      assert (fw_app_mode === pend_mode) else begin
        abort_run($sformatf("error: fw_app_mode expected 0x%0h got 0x%0h",
                            pend_mode, fw_app_mode));
      end
      if (pend_cs) begin
        assert (rsp.rdata === pend_rdata) else begin
          abort_run($sformatf("error: rsp.rdata expected 0x%08h got 0x%08h",
                              pend_rdata, rsp.rdata));
        end
        checked++;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        abort_run($sformatf("timeout after %0d cycles, the run did not finish", cycles));
      end
    end
  end

endmodule

//--- verif/tb_clkgen.sv
// Testbench clock and reset source; a rising reset_req runs the reset sequence again

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  input  logic reset_req,
  output logic clk,
  output logic reset_n
);

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset changes only on falling edges, held for RESET_CYCLES rising edges
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    forever begin
      @(posedge reset_req);
      @(negedge clk);
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;
    end
  end

endmodule
